/* hw/cart_pkg.sv */
// Cartridge format definitions
// Header word views, mapper overrides, work-RAM fill patterns and offsets
`default_nettype none

package cart_pkg;

	// ============================================================
	// Address masks
	// ============================================================
	localparam int MASK_W    = 24;
	localparam int MASK_BASE = 1024;

	typedef logic [MASK_W-1:0] mask_t;

	// Header override as selected by the user
	typedef enum logic [2:0] {
		MAP_AUTO    = 3'd0,
		MAP_NOHDR   = 3'd1,
		MAP_LOROM   = 3'd2,
		MAP_HIROM   = 3'd3,
		MAP_EXHIROM = 3'd4
	} mapper_sel_t;

	// Power-on content of the work RAM
	typedef enum logic [1:0] {
		FILL_9966 = 2'd0,
		FILL_00FF = 2'd1,
		FILL_55   = 2'd2,
		FILL_FF   = 2'd3
	} fill_pattern_t;

	// ============================================================
	// Header word, read two ways
	// ============================================================
	// Copier header, word 0: type byte high, size byte low
	typedef struct packed {
		logic [7:0] type_byte;
		logic [3:0] ram_size;
		logic [3:0] rom_size;
	} copier_word_t;

	// Internal header: ROM size in the high byte, RAM size in the next word's low byte
	typedef struct packed {
		logic [3:0] pad_hi;
		logic [3:0] rom_size;
		logic [3:0] pad_lo;
		logic [3:0] ram_size;
	} internal_word_t;

	typedef union packed {
		copier_word_t   copier;
		internal_word_t internal;
	} hdr_word_t;

	// Byte offsets of the size field inside the image
	localparam int COPIER_SIZE      = 512;
	localparam int LOROM_SIZE_OFS   = 'h7FD6;
	localparam int HIROM_SIZE_OFS   = 'hFFD6;
	localparam int EXHIROM_SIZE_OFS = 'h40FFD6;
	localparam int RAM_SIZE_DELTA   = 2;

	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'hC;

	// 512-byte save sectors
	localparam int SECTOR_SHIFT = 9;

endpackage

`default_nettype wire

/* hw/host_pkg.sv */
// Host transfer definitions
// Download bus from the host and the SD sector request toward it
`default_nettype none

package host_pkg;

	// ============================================================
	// Download bus
	// ============================================================
	localparam int DL_INDEX_W = 8;
	localparam int DL_ADDR_W  = 25;
	localparam int DL_DATA_W  = 16;

	typedef logic [DL_ADDR_W-1:0] dl_addr_t;

	// Low index bits of a cartridge image
	localparam logic [5:0] CART_INDEX = 6'd0;

	typedef struct packed {
		logic                  active;
		logic [DL_INDEX_W-1:0] index;
		dl_addr_t              addr;
		logic [DL_DATA_W-1:0]  data;
		logic                  wr;
	} dl_bus_t;

	// ============================================================
	// Sector request
	// ============================================================
	localparam int LBA_W = 32;

	// rd and wr are levels, dropped by the host acknowledge
	typedef struct packed {
		logic             rd;
		logic             wr;
		logic [LBA_W-1:0] lba;
	} sd_req_t;

endpackage

`default_nettype wire

/* hw/rom_header_detect.sv */
// ROM header detector
// Reads copier and internal headers from the download stream into type, masks, region
`timescale 1ns/1ps
`default_nettype none

module rom_header_detect
	import cart_pkg::*, host_pkg::*;
(
	input  wire              clk_sys,
	input  wire              RESET,
	input  wire dl_bus_t     dl,
	input  wire              cart_download,
	input  wire mapper_sel_t mapper_sel,
	input  wire [1:0]        region_sel,
	output logic [7:0]       rom_type,
	output mask_t            rom_mask,
	output mask_t            ram_mask,
	output logic             pal
);

	hdr_word_t  hdr_word;
	logic       hdr_wr;
	logic       use_internal;
	dl_addr_t   size_addr;
	dl_addr_t   ram_addr;
	logic [3:0] rom_size;
	logic [3:0] ram_size;
	logic [3:0] rom_size_nx;
	logic [3:0] ram_size_nx;
	logic [7:0] type_nx;
	logic       rom_region;

	function automatic mask_t size_to_mask(input logic [3:0] size);
		return (mask_t'(MASK_BASE) << size) - 1'b1;
	endfunction

	assign hdr_word = dl.data;
	assign hdr_wr   = cart_download && dl.wr;

	// ============================================================
	// Internal header location for the forced mapper
	// ============================================================
	always_comb begin
		use_internal = 1'b1;
		case (mapper_sel)
			MAP_LOROM:   size_addr = dl_addr_t'(LOROM_SIZE_OFS + COPIER_SIZE);
			MAP_HIROM:   size_addr = dl_addr_t'(HIROM_SIZE_OFS + COPIER_SIZE);
			MAP_EXHIROM: size_addr = dl_addr_t'(EXHIROM_SIZE_OFS + COPIER_SIZE);
			default: begin
				size_addr    = '0;
				use_internal = 1'b0;
			end
		endcase
	end

	// RAM size sits one word after the ROM size
	assign ram_addr = size_addr + dl_addr_t'(RAM_SIZE_DELTA);

	// Size fields as they will be after this write
	always_comb begin
		rom_size_nx = rom_size;
		ram_size_nx = ram_size;
		if (dl.addr == '0) begin
			rom_size_nx = DEFAULT_ROM_SIZE;
			ram_size_nx = 4'd0;
			if (mapper_sel == MAP_AUTO &&
			    {hdr_word.copier.ram_size, hdr_word.copier.rom_size} != 8'd0) begin
				rom_size_nx = hdr_word.copier.rom_size;
				ram_size_nx = hdr_word.copier.ram_size;
			end
		end
		if (use_internal) begin
			if (dl.addr == size_addr)
				rom_size_nx = hdr_word.internal.rom_size;
			if (dl.addr == ram_addr)
				ram_size_nx = hdr_word.internal.ram_size;
		end
	end

	always_comb begin
		case (mapper_sel)
			MAP_NOHDR,
			MAP_LOROM:   type_nx = 8'd0;
			MAP_HIROM:   type_nx = 8'd1;
			MAP_EXHIROM: type_nx = 8'd2;
			default:     type_nx = hdr_word.copier.type_byte;
		endcase
	end

	// ============================================================
	// Captured fields and masks
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_type   <= '0;
			rom_mask   <= '0;
			ram_mask   <= '0;
			rom_size   <= '0;
			ram_size   <= '0;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else begin
			if (hdr_wr) begin
				rom_size <= rom_size_nx;
				ram_size <= ram_size_nx;
				if (dl.addr == '0)
					rom_type <= type_nx;
				// Region flag of the copier header
				if (dl.addr == dl_addr_t'(2))
					rom_region <= dl.data[8];
				rom_mask <= size_to_mask(rom_size_nx);
				ram_mask <= (ram_size_nx != 4'd0) ? size_to_mask(ram_size_nx) : '0;
			end
			// Region stays frozen while an image streams in
			if (!cart_download)
				pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

	a_mask_only_on_download: assert property (@(posedge clk_sys) disable iff (RESET)
		(!$past(RESET) && (!$stable(rom_mask) || !$stable(ram_mask)))
		|-> $past(cart_download && dl.wr));

endmodule

`default_nettype wire

/* hw/ram_clear.sv */
// Work-RAM clearer
// Sweeps the RAM address space once per download and emits pattern write strobes
`timescale 1ns/1ps
`default_nettype none

module ram_clear
	import cart_pkg::*;
#(
	parameter int FILL_BITS = 17
) (
	input  wire                  clk_sys,
	input  wire                  RESET,
	input  wire                  cart_download,
	input  wire fill_pattern_t   fill_pattern,
	output logic                 clearing,
	output logic                 fill_we,
	output logic [FILL_BITS-1:0] fill_addr,
	output logic [7:0]           fill_data
);

	logic       dl_prev;
	logic       dl_start;
	logic [9:0] pat_addr;

	assign dl_start = cart_download && !dl_prev;

	// ============================================================
	// Address sweep
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_prev   <= 1'b0;
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else begin
			dl_prev <= cart_download;
			if (&fill_addr)
				clearing <= 1'b0;
			else if (dl_start)
				clearing <= 1'b1;
			fill_addr <= clearing ? fill_addr + 1'b1 : '0;
		end
	end

	assign fill_we = clearing;

	// Pattern bits above the RAM width read as zero
	assign pat_addr = 10'(fill_addr);

	always_comb begin
		case (fill_pattern)
			FILL_9966: fill_data = (pat_addr[8] ^ pat_addr[2]) ? 8'h66 : 8'h99;
			FILL_00FF: fill_data = (pat_addr[9] ^ pat_addr[0]) ? 8'hFF : 8'h00;
			FILL_55:   fill_data = 8'h55;
			default:   fill_data = 8'hFF;
		endcase
	end

	a_addr_moves_when_clearing: assert property (@(posedge clk_sys) disable iff (RESET)
		(!$past(RESET) && !$stable(fill_addr)) |-> $past(clearing));

endmodule

`default_nettype wire

/* hw/backup_sync.sv */
// Backup-RAM synchronizer
// Save enable, sector load and save sequencing, and the combined core reset
`timescale 1ns/1ps
`default_nettype none

module backup_sync
	import cart_pkg::*, host_pkg::*;
(
	input  wire        clk_sys,
	input  wire        RESET,
	input  wire        cart_download,
	input  wire mask_t ram_mask,
	input  wire        clearing,
	input  wire        img_mounted,
	input  wire        img_readonly,
	input  wire        img_size_nz,
	input  wire        bk_load_req,
	input  wire        bk_save_req,
	input  wire        sd_ack,
	output sd_req_t    sd,
	output logic       bk_ena,
	output logic       bk_loading,
	output logic       core_reset
);

	logic             dl_prev;
	logic             load_prev;
	logic             save_prev;
	logic             ack_prev;
	logic             busy;
	logic             dl_rise;
	logic             auto_load;
	logic             load_edge;
	logic             save_edge;
	logic             ack_rise;
	logic             ack_fall;
	logic [LBA_W-1:0] last_lba;

	// ============================================================
	// Edge detection
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_prev   <= 1'b0;
			load_prev <= 1'b0;
			save_prev <= 1'b0;
			ack_prev  <= 1'b0;
		end else begin
			dl_prev   <= cart_download;
			load_prev <= bk_load_req;
			save_prev <= bk_save_req;
			ack_prev  <= sd_ack;
		end
	end

	assign dl_rise   = cart_download && !dl_prev;
	// Save file is already mounted when the download ends
	assign auto_load = dl_prev && !cart_download && img_size_nz && bk_ena;
	assign load_edge = bk_load_req && !load_prev && bk_ena;
	assign save_edge = bk_save_req && !save_prev && bk_ena;
	assign ack_rise  = sd_ack && !ack_prev;
	assign ack_fall  = !sd_ack && ack_prev;

	assign last_lba = LBA_W'(ram_mask >> SECTOR_SHIFT);

	// ============================================================
	// Backup enable
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_ena <= 1'b0;
		end else begin
			if (dl_rise)
				bk_ena <= 1'b0;
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;
		end
	end

	// ============================================================
	// Sector sequencer
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			busy       <= 1'b0;
			bk_loading <= 1'b0;
			sd.rd      <= 1'b0;
			sd.wr      <= 1'b0;
		end else begin
			// Host has taken the request
			if (ack_rise) begin
				sd.rd <= 1'b0;
				sd.wr <= 1'b0;
			end

			if (!busy) begin
				if (auto_load || load_edge || save_edge) begin
					busy       <= 1'b1;
					bk_loading <= auto_load || load_edge;
					sd.lba     <= '0;
					sd.rd      <= auto_load || load_edge;
					sd.wr      <= !(auto_load || load_edge);
				end
			end else if (ack_fall) begin
				if (sd.lba >= last_lba) begin
					busy       <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd.lba <= sd.lba + 1'b1;
					sd.rd  <= bk_loading;
					sd.wr  <= !bk_loading;
				end
			end
		end
	end

	// Core held in reset until all loading has settled
	always_ff @(posedge clk_sys) begin
		core_reset <= RESET || cart_download || clearing || bk_loading;
	end

	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd.rd && sd.wr));

	a_request_only_when_busy: assert property (@(posedge clk_sys) disable iff (RESET)
		(sd.rd || sd.wr) |-> busy);

endmodule

`default_nettype wire

/* hw/cart_loader_top.sv */
// Cartridge loader top level
// Header detector and RAM clearer run side by side, backup sync combines them
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top
	import cart_pkg::*, host_pkg::*;
#(
	parameter int FILL_BITS = 17
) (
	input  wire                  clk_sys,
	input  wire                  RESET,
	input  wire dl_bus_t         dl,
	input  wire mapper_sel_t     mapper_sel,
	input  wire [1:0]            region_sel,
	input  wire fill_pattern_t   fill_pattern,
	input  wire                  img_mounted,
	input  wire                  img_readonly,
	input  wire                  img_size_nz,
	input  wire                  bk_load_req,
	input  wire                  bk_save_req,
	input  wire                  sd_ack,
	output logic [7:0]           rom_type,
	output mask_t                rom_mask,
	output mask_t                ram_mask,
	output logic                 pal,
	output logic                 fill_we,
	output logic [FILL_BITS-1:0] fill_addr,
	output logic [7:0]           fill_data,
	output sd_req_t              sd,
	output logic                 bk_ena,
	output logic                 bk_loading,
	output logic                 core_reset
);

	logic cart_download;
	logic clearing;

	// Cartridge images only, other indexes are ignored
	assign cart_download = dl.active && (dl.index[5:0] == CART_INDEX);

	rom_header_detect u_hdr (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.dl            (dl),
		.cart_download (cart_download),
		.mapper_sel    (mapper_sel),
		.region_sel    (region_sel),
		.rom_type      (rom_type),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask),
		.pal           (pal)
	);

	ram_clear #(
		.FILL_BITS (FILL_BITS)
	) u_clear (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.fill_pattern  (fill_pattern),
		.clearing      (clearing),
		.fill_we       (fill_we),
		.fill_addr     (fill_addr),
		.fill_data     (fill_data)
	);

	backup_sync u_bk (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.ram_mask      (ram_mask),
		.clearing      (clearing),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size_nz   (img_size_nz),
		.bk_load_req   (bk_load_req),
		.bk_save_req   (bk_save_req),
		.sd_ack        (sd_ack),
		.sd            (sd),
		.bk_ena        (bk_ena),
		.bk_loading    (bk_loading),
		.core_reset    (core_reset)
	);

endmodule

`default_nettype wire

/* bench/tb_cart_loader.sv */
// Cartridge loader testbench
// Streams ROM headers from the stim file, models the SD acknowledge, checks results
`timescale 1ns/1ps
`default_nettype none

module tb_cart_loader
	import cart_pkg::*, host_pkg::*;
();

	localparam int FILL_BITS  = 10;
	localparam int FILL_WORDS = 1 << FILL_BITS;
	localparam int NUM_TESTS  = 4;
	localparam int FIELDS     = 12;
	localparam int MAX_DELAY  = 6;
	localparam int STEP_LIMIT = 200;

	localparam logic [31:0] SEED = 32'hf5df_cb9a;

	// Columns of one stim line
	localparam int F_MAP      = 0;
	localparam int F_REGION   = 1;
	localparam int F_FILL     = 2;
	localparam int F_WORD0    = 3;
	localparam int F_WORD2    = 4;
	localparam int F_SIZE     = 5;
	localparam int F_RAM      = 6;
	localparam int F_TYPE     = 7;
	localparam int F_ROM_MASK = 8;
	localparam int F_RAM_MASK = 9;
	localparam int F_PAL      = 10;
	localparam int F_ACTION   = 11;

	localparam logic [31:0] ACT_NONE = 32'd0;
	localparam logic [31:0] ACT_LOAD = 32'd1;
	localparam logic [31:0] ACT_SAVE = 32'd2;

	logic                 clk_sys;
	logic                 RESET;
	dl_bus_t              dl;
	mapper_sel_t          mapper_sel;
	logic [1:0]           region_sel;
	fill_pattern_t        fill_pattern;
	logic                 img_mounted;
	logic                 img_readonly;
	logic                 img_size_nz;
	logic                 bk_load_req;
	logic                 bk_save_req;
	logic                 sd_ack;
	logic [7:0]           rom_type;
	mask_t                rom_mask;
	mask_t                ram_mask;
	logic                 pal;
	logic                 fill_we;
	logic [FILL_BITS-1:0] fill_addr;
	logic [7:0]           fill_data;
	sd_req_t              sd;
	logic                 bk_ena;
	logic                 bk_loading;
	logic                 core_reset;

	logic [31:0] stim [0:NUM_TESTS*FIELDS-1];
	logic [31:0] cur [0:FIELDS-1];
	string       cur_name;
	int          fill_count  = 0;
	int          budget      = 0;

	cart_loader_top #(
		.FILL_BITS (FILL_BITS)
	) UUT (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl           (dl),
		.mapper_sel   (mapper_sel),
		.region_sel   (region_sel),
		.fill_pattern (fill_pattern),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size_nz  (img_size_nz),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.sd_ack       (sd_ack),
		.rom_type     (rom_type),
		.rom_mask     (rom_mask),
		.ram_mask     (ram_mask),
		.pal          (pal),
		.fill_we      (fill_we),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data),
		.sd           (sd),
		.bk_ena       (bk_ena),
		.bk_loading   (bk_loading),
		.core_reset   (core_reset)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ============================================================
	// Reporting and compare tasks
	// ============================================================
	task automatic fail_run();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic report_stall(input string what);
		$display("Error in %s: %s did not happen in time", cur_name, what);
		fail_run();
	endtask

	task automatic check_mask(input string what, input mask_t exp, input mask_t act);
		if (act !== exp) begin
			$display("Fail %s %s: expected %h, actual %h", cur_name, what, exp, act);
			fail_run();
		end
	endtask

	task automatic check_req(input string what, input sd_req_t exp, input sd_req_t act);
		if (act !== exp) begin
			$display("Fail %s %s: expected rd=%b wr=%b lba=%0d, actual rd=%b wr=%b lba=%0d",
				cur_name, what, exp.rd, exp.wr, exp.lba, act.rd, act.wr, act.lba);
			fail_run();
		end
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Fail %s %s: expected %h, actual %h", cur_name, what, exp, act);
			fail_run();
		end
	endtask

	task automatic check_addr(input string what, input logic [FILL_BITS-1:0] exp,
			input logic [FILL_BITS-1:0] act);
		if (act !== exp) begin
			$display("Fail %s %s: expected %0d, actual %0d", cur_name, what, exp, act);
			fail_run();
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s %s: expected %b, actual %b", cur_name, what, exp, act);
			fail_run();
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (act != exp) begin
			$display("Fail %s %s: expected %0d, actual %0d", cur_name, what, exp, act);
			fail_run();
		end
	endtask

	// Work-RAM power-on content by pattern
	function automatic logic [7:0] pattern_byte(input fill_pattern_t pat, input logic [31:0] addr);
		logic [7:0] value;
		case (pat)
			FILL_9966: value = (addr[8] == addr[2]) ? 8'h99 : 8'h66;
			FILL_00FF: value = (addr[9] == addr[0]) ? 8'h00 : 8'hFF;
			FILL_55:   value = 8'h55;
			default:   value = 8'hFF;
		endcase
		return value;
	endfunction

	function automatic logic [31:0] last_sector();
		return cur[F_RAM_MASK] >> SECTOR_SHIFT;
	endfunction

	// Cycle budget summed over all tests in the stim file
	function automatic int run_budget();
		int          total;
		logic [31:0] sectors;
		total = 16;
		for (int t = 0; t < NUM_TESTS; t++) begin
			sectors = (stim[t * FIELDS + F_RAM_MASK] >> SECTOR_SHIFT) + 1;
			total   = total + FILL_WORDS + 100;
			if (stim[t * FIELDS + F_ACTION] != ACT_NONE)
				total = total + int'(sectors) * (2 * MAX_DELAY + 8);
		end
		return total * 4;
	endfunction

	// Fill strobes must come in address order with the pattern data
	always @(negedge clk_sys) begin
		if (fill_we === 1'b1) begin
			check_addr("fill_addr", fill_count[FILL_BITS-1:0], fill_addr);
			check_byte("fill_data", pattern_byte(fill_pattern, fill_count), fill_data);
			fill_count = fill_count + 1;
		end
	end

	// ============================================================
	// Download and sector tasks
	// ============================================================
	task automatic write_word(input dl_addr_t addr, input logic [15:0] data);
		@(posedge clk_sys);
		dl.addr <= addr;
		dl.data <= data;
		dl.wr   <= 1'b1;
		@(posedge clk_sys);
		dl.wr <= 1'b0;
	endtask

	task automatic load_image();
		mapper_sel_t map;
		dl_addr_t    size_addr;
		logic        has_internal;
		int          wait_n;
		map          = mapper_sel_t'(cur[F_MAP][2:0]);
		has_internal = 1'b1;
		case (map)
			MAP_LOROM:   size_addr = dl_addr_t'(LOROM_SIZE_OFS + COPIER_SIZE);
			MAP_HIROM:   size_addr = dl_addr_t'(HIROM_SIZE_OFS + COPIER_SIZE);
			MAP_EXHIROM: size_addr = dl_addr_t'(EXHIROM_SIZE_OFS + COPIER_SIZE);
			default: begin
				size_addr    = '0;
				has_internal = 1'b0;
			end
		endcase
		@(posedge clk_sys);
		mapper_sel   <= map;
		region_sel   <= cur[F_REGION][1:0];
		fill_pattern <= fill_pattern_t'(cur[F_FILL][1:0]);
		img_size_nz  <= (cur[F_ACTION] == ACT_LOAD);
		fill_count = 0;
		@(posedge clk_sys);
		dl.active <= 1'b1;
		dl.index  <= 8'h00;
		write_word('0, cur[F_WORD0][15:0]);
		write_word(dl_addr_t'(2), cur[F_WORD2][15:0]);
		if (has_internal) begin
			write_word(size_addr, cur[F_SIZE][15:0]);
			write_word(size_addr + dl_addr_t'(2), cur[F_RAM][15:0]);
		end
		// Save image mounted while the cart streams in
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		// Download stays open until the RAM clear has finished
		wait_n = 0;
		@(negedge clk_sys);
		while (fill_count == 0 || fill_we) begin
			wait_n++;
			if (wait_n > 2 * FILL_WORDS)
				report_stall("end of the RAM clear");
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		dl.active <= 1'b0;
	endtask

	task automatic check_cart_info();
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_byte("rom_type", cur[F_TYPE][7:0], rom_type);
		check_mask("rom_mask", cur[F_ROM_MASK][MASK_W-1:0], rom_mask);
		check_mask("ram_mask", cur[F_RAM_MASK][MASK_W-1:0], ram_mask);
		check_bit("pal", cur[F_PAL][0], pal);
		check_count("fill strobes", FILL_WORDS, fill_count);
	endtask

	// Host side of the sector handshake with random acknowledge latency
	task automatic serve_sectors(input logic is_read, input logic [31:0] last);
		sd_req_t     exp_req;
		logic [31:0] lba;
		int          wait_n;
		for (lba = 0; lba <= last; lba++) begin
			wait_n = 0;
			@(negedge clk_sys);
			while (!(sd.rd || sd.wr)) begin
				wait_n++;
				if (wait_n > STEP_LIMIT)
					report_stall("sector request");
				@(negedge clk_sys);
			end
			exp_req.rd  = is_read;
			exp_req.wr  = !is_read;
			exp_req.lba = lba;
			check_req("sector request", exp_req, sd);
			repeat ($urandom % MAX_DELAY) @(posedge clk_sys);
			@(posedge clk_sys);
			sd_ack <= 1'b1;
			wait_n = 0;
			@(negedge clk_sys);
			while (sd.rd || sd.wr) begin
				wait_n++;
				if (wait_n > STEP_LIMIT)
					report_stall("request drop after sd_ack");
				@(negedge clk_sys);
			end
			repeat ($urandom % MAX_DELAY) @(posedge clk_sys);
			@(posedge clk_sys);
			sd_ack <= 1'b0;
		end
	endtask

	task automatic run_load();
		int wait_n;
		check_bit("bk_loading at load start", 1'b1, bk_loading);
		serve_sectors(1'b1, last_sector());
		wait_n = 0;
		@(negedge clk_sys);
		while (bk_loading) begin
			wait_n++;
			if (wait_n > STEP_LIMIT)
				report_stall("end of the backup load");
			@(negedge clk_sys);
		end
		check_bit("core_reset as load ends", 1'b1, core_reset);
		@(negedge clk_sys);
		check_bit("core_reset after load", 1'b0, core_reset);
		check_bit("sd.rd after load", 1'b0, sd.rd);
	endtask

	task automatic run_save();
		check_bit("bk_ena", 1'b1, bk_ena);
		@(posedge clk_sys);
		bk_save_req <= 1'b1;
		serve_sectors(1'b0, last_sector());
		@(posedge clk_sys);
		bk_save_req <= 1'b0;
		repeat (8) begin
			@(negedge clk_sys);
			check_bit("sd.wr after save", 1'b0, sd.wr);
		end
	endtask

	// Without backup RAM a save request must be ignored
	task automatic expect_no_save();
		check_bit("bk_ena", 1'b0, bk_ena);
		@(posedge clk_sys);
		bk_save_req <= 1'b1;
		repeat (16) begin
			@(negedge clk_sys);
			check_bit("sd.rd", 1'b0, sd.rd);
			check_bit("sd.wr", 1'b0, sd.wr);
		end
		@(posedge clk_sys);
		bk_save_req <= 1'b0;
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		void'($urandom(SEED));
		cur_name = "setup";
		$readmemh("bench/cart_stim.mem", stim);
		if ($isunknown(stim[NUM_TESTS*FIELDS-1])) begin
			$display("Error: the stim file is missing or has too few entries");
			fail_run();
		end
		budget = run_budget();
		RESET        <= 1'b1;
		dl           <= '0;
		mapper_sel   <= MAP_AUTO;
		region_sel   <= 2'd0;
		fill_pattern <= FILL_9966;
		img_mounted  <= 1'b0;
		img_readonly <= 1'b0;
		img_size_nz  <= 1'b0;
		bk_load_req  <= 1'b0;
		bk_save_req  <= 1'b0;
		sd_ack       <= 1'b0;
		repeat (8) @(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		cur_name = "reset";
		check_byte("rom_type", 8'h00, rom_type);
		check_mask("rom_mask", '0, rom_mask);
		check_mask("ram_mask", '0, ram_mask);
		check_bit("fill_we", 1'b0, fill_we);
		check_bit("sd.rd", 1'b0, sd.rd);
		check_bit("sd.wr", 1'b0, sd.wr);
		check_bit("bk_loading", 1'b0, bk_loading);
		for (int t = 0; t < NUM_TESTS; t++) begin
			cur_name = $sformatf("test%0d", t);
			for (int i = 0; i < FIELDS; i++)
				cur[i] = stim[t * FIELDS + i];
			load_image();
			check_cart_info();
			case (cur[F_ACTION])
				ACT_LOAD: run_load();
				ACT_SAVE: run_save();
				default:  expect_no_save();
			endcase
		end
		repeat (4) @(posedge clk_sys);
		$display("test passed");
		$finish;
	end

	// Watchdog
	initial begin
		#1;
		repeat (budget) @(posedge clk_sys);
		$display("Error: watchdog expired after %0d cycles, the run hung", budget);
		fail_run();
	end

endmodule

`default_nettype wire

/* bench/cart_stim.mem */
// One test per line, hex fields in this order:
// mapper region fill word0 word2 size_word ram_word type rom_mask ram_mask pal action
// mapper 0 auto, 3 HiROM, 4 ExHiROM; region 0 auto, 1 NTSC, 2 PAL
// fill 0 9966, 1 00FF, 2 55, 3 FF
// action 0 save request ignored, 1 auto-load after download, 2 manual save
//
// Auto mapper, copier sizes ROM 9 RAM 1, type 2, region bit set
0 0 0 0219 0100 0000 0000 02 7FFFF 7FF 1 1
// Auto mapper, zero size byte gives ROM C and no RAM, forced NTSC
0 1 1 0500 0100 0000 0000 05 3FFFFF 0 0 0
// HiROM override, internal ROM A RAM 2, forced PAL
3 2 2 00AB 0000 0A00 0002 01 FFFFF FFF 1 2
// ExHiROM override, internal ROM B RAM 1, region bit clear
4 0 3 0311 0000 0B00 0001 02 1FFFFF 7FF 0 1

/* flist.f */
hw/cart_pkg.sv
hw/host_pkg.sv
hw/rom_header_detect.sv
hw/ram_clear.sv
hw/backup_sync.sv
hw/cart_loader_top.sv
bench/tb_cart_loader.sv

/* Makefile */
TOP = tb_cart_loader

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir

# Exit status comes from the search for the pass message
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
